// File: hdl/ubaPkg.sv
/*
 * Bus adapter DMA path definitions
 * Widths, page-table entry, device request/response and backplane bundles
 */

`default_nettype none

package ubaPkg;

   ////////////////////
   // Widths and counts
   ////////////////////

   // Backplane word and device halfword
   localparam int unsigned wordWidth     = 36;
   localparam int unsigned halfWidth     = 18;
   // Device byte address and backplane word address
   localparam int unsigned devAddrWidth  = 18;
   localparam int unsigned busAddrWidth  = 20;
   // Page table size
   localparam int unsigned pageCount     = 64;
   localparam int unsigned pageNumWidth  = $clog2(pageCount);
   localparam int unsigned physPageWidth = 10;
   // Device address fields
   localparam int unsigned pageLsb       = 12;
   localparam int unsigned offsetLsb     = 2;
   localparam int unsigned halfSelBit    = 1;

   ////////////////////
   // Types
   ////////////////////

   // One page-table entry, fill is reserved
   typedef struct packed {
      logic                     valid;
      logic                     rpw;
      logic                     fill;
      logic [physPageWidth-1:0] physPage;
   } pageEntry_t;

   typedef enum logic {
      devRead  = 1'b0,
      devWrite = 1'b1
   } devOp_t;

   // Device request, addr bit 1 picks the halfword
   typedef struct packed {
      devOp_t                  op;
      logic [devAddrWidth-1:0] addr;
      logic [halfWidth-1:0]    data;
   } devReq_t;

   typedef struct packed {
      logic                 err;
      logic [halfWidth-1:0] data;
   } devResp_t;

   // NPR sequencer states
   typedef enum logic [3:0] {
      stIdle, stXlate, stRdStb, stRdAck,
      stPause, stWrStb, stWrAck, stDone
   } nprState_t;

   // Wishbone classic master outputs
   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic                    we;
      logic [busAddrWidth-1:0] adr;
      logic [wordWidth-1:0]    dat;
   } wbMaster_t;

endpackage

`default_nettype wire

// File: hdl/ubaPager.sv
/*
 * Bus adapter pager
 * 64-entry page table with a config write port and a registered lookup
 */

`default_nettype none

module ubaPager (
   input  logic                              clk,
   input  logic                              rst,
   // Configuration port
   input  logic                              cfgWrite,
   input  logic [ubaPkg::pageNumWidth-1:0]   cfgPage,
   input  ubaPkg::pageEntry_t                cfgEntry,
   // Translation port
   input  logic [ubaPkg::devAddrWidth-1:0]   xlateAddr,
   output ubaPkg::pageEntry_t                xlateEntry
);

   // Valid bits live apart so reset can clear them
   logic [ubaPkg::pageCount-1:0]           validBits;
   // Rest of each entry, valid field in here is unused
   ubaPkg::pageEntry_t                     pageTable [ubaPkg::pageCount];
   logic [ubaPkg::pageNumWidth-1:0]        xlatePage;
   logic                                   rdValid;
   ubaPkg::pageEntry_t                     rdEntry;

   // Page number is the top six address bits
   assign xlatePage = xlateAddr[ubaPkg::devAddrWidth-1:ubaPkg::pageLsb];

   ////////////////////
   // Table write
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         validBits <= '0;
      end
      else if (cfgWrite)
      begin
         validBits[cfgPage] <= cfgEntry.valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (cfgWrite)
      begin
         pageTable[cfgPage] <= cfgEntry;
      end
   end

   ////////////////////
   // Lookup
   ////////////////////

   // Registered every cycle; same-page write returns old entry
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdValid <= 1'b0;
      end
      else
      begin
         rdValid <= validBits[xlatePage];
      end
   end

   always_ff @(posedge clk)
   begin
      rdEntry <= pageTable[xlatePage];
   end

   // Reassemble with the resettable valid bit
   assign xlateEntry = '{
      valid:    rdValid,
      rpw:      rdEntry.rpw,
      fill:     rdEntry.fill,
      physPage: rdEntry.physPage
   };

endmodule

`default_nettype wire

// File: hdl/ubaNpr.sv
/*
 * Bus adapter NPR sequencer
 * Arbitrates two devices and runs read, write and read-pause-write
 * Wishbone cycles on the backplane, then acknowledges the device
 */

`default_nettype none

module ubaNpr (
   input  logic                              clk,
   input  logic                              rst,
   // Device 1, highest priority
   input  logic                              devReqValid1,
   input  ubaPkg::devReq_t                   devReq1,
   output logic                              devAck1,
   // Device 2
   input  logic                              devReqValid2,
   input  ubaPkg::devReq_t                   devReq2,
   output logic                              devAck2,
   // Shared response, valid with either ack
   output ubaPkg::devResp_t                  devResp,
   // Pager
   output logic [ubaPkg::devAddrWidth-1:0]   xlateAddr,
   input  ubaPkg::pageEntry_t                xlateEntry,
   // Backplane master
   output ubaPkg::wbMaster_t                 busOut,
   input  logic [ubaPkg::wordWidth-1:0]      busDatIn,
   input  logic                              busAck
);

   ubaPkg::nprState_t                  state;
   ubaPkg::nprState_t                  nextState;
   // Arbitration
   logic                               anyValid;
   ubaPkg::devReq_t                    winner;
   logic                               grantDev2;
   // Latched request
   ubaPkg::devReq_t                    req;
   logic                               oddHalf;
   // Backplane registers
   logic                               busCyc;
   logic                               busStb;
   logic                               busWe;
   logic [ubaPkg::busAddrWidth-1:0]    busAdr;
   logic [ubaPkg::wordWidth-1:0]       busDat;
   // Data path
   logic [ubaPkg::halfWidth-1:0]       rdHalf;
   logic [ubaPkg::wordWidth-1:0]       mergedWord;
   logic [ubaPkg::wordWidth-1:0]       plainWord;
   logic                               respErr;
   logic [ubaPkg::halfWidth-1:0]       respData;

   ////////////////////
   // Arbitration
   ////////////////////

   // Fixed priority, device 1 wins a tie
   assign anyValid = devReqValid1 || devReqValid2;
   assign winner   = devReqValid1 ? devReq1 : devReq2;

   // Idle drives the live winner so the pager has it one cycle early
   assign xlateAddr = (state == ubaPkg::stIdle) ? winner.addr : req.addr;

   ////////////////////
   // Halfword data path
   ////////////////////

   // Address bit 1 set means the right (odd) halfword
   assign oddHalf = req.addr[ubaPkg::halfSelBit];

   assign rdHalf = oddHalf ? busDatIn[ubaPkg::halfWidth-1:0]
                           : busDatIn[ubaPkg::wordWidth-1:ubaPkg::halfWidth];

   // RPW merge keeps the other half of the word just read
   assign mergedWord = oddHalf ?
      {busDatIn[ubaPkg::wordWidth-1:ubaPkg::halfWidth], req.data} :
      {req.data, busDatIn[ubaPkg::halfWidth-1:0]};

   // Plain write zeroes the other half
   assign plainWord = oddHalf ? {{ubaPkg::halfWidth{1'b0}}, req.data}
                              : {req.data, {ubaPkg::halfWidth{1'b0}}};

   ////////////////////
   // Next state
   ////////////////////

   always_comb
   begin
      nextState = state;
      case (state)
         ubaPkg::stIdle:
            if (anyValid)
            begin
               nextState = ubaPkg::stXlate;
            end
         // Entry for the latched address is on xlateEntry now
         ubaPkg::stXlate:
            if (!xlateEntry.valid)
            begin
               nextState = ubaPkg::stDone;
            end
            else if (req.op == ubaPkg::devRead || xlateEntry.rpw)
            begin
               nextState = ubaPkg::stRdStb;
            end
            else
            begin
               nextState = ubaPkg::stWrStb;
            end
         ubaPkg::stRdStb:
            nextState = ubaPkg::stRdAck;
         // Read done, or first half of RPW
         ubaPkg::stRdAck:
            if (busAck)
            begin
               nextState = (req.op == ubaPkg::devRead) ? ubaPkg::stDone
                                                       : ubaPkg::stPause;
            end
         ubaPkg::stPause:
            nextState = ubaPkg::stWrStb;
         ubaPkg::stWrStb:
            nextState = ubaPkg::stWrAck;
         ubaPkg::stWrAck:
            if (busAck)
            begin
               nextState = ubaPkg::stDone;
            end
         ubaPkg::stDone:
            nextState = ubaPkg::stIdle;
         default:
            nextState = ubaPkg::stIdle;
      endcase
   end

   ////////////////////
   // Control registers
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state     <= ubaPkg::stIdle;
         grantDev2 <= 1'b0;
         busCyc    <= 1'b0;
         busStb    <= 1'b0;
         busWe     <= 1'b0;
         devAck1   <= 1'b0;
         devAck2   <= 1'b0;
      end
      else
      begin
         state <= nextState;
         if (state == ubaPkg::stIdle && anyValid)
         begin
            grantDev2 <= !devReqValid1;
         end
         // Cycle is open exactly in the ack states
         busCyc  <= nextState == ubaPkg::stRdAck || nextState == ubaPkg::stWrAck;
         busStb  <= nextState == ubaPkg::stRdAck || nextState == ubaPkg::stWrAck;
         busWe   <= nextState == ubaPkg::stWrAck;
         // One-cycle ack to the granted device
         devAck1 <= nextState == ubaPkg::stDone && !grantDev2;
         devAck2 <= nextState == ubaPkg::stDone && grantDev2;
      end
   end

   ////////////////////
   // Payload registers
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (state == ubaPkg::stIdle && anyValid)
      begin
         req <= winner;
      end
      // Word address is physical page plus word offset
      if (state == ubaPkg::stXlate)
      begin
         busAdr   <= {xlateEntry.physPage,
                      req.addr[ubaPkg::pageLsb-1:ubaPkg::offsetLsb]};
         busDat   <= plainWord;
         respErr  <= !xlateEntry.valid;
         respData <= '0;
      end
      if (state == ubaPkg::stRdAck && busAck)
      begin
         busDat <= mergedWord;
         if (req.op == ubaPkg::devRead)
         begin
            respData <= rdHalf;
         end
      end
   end

   assign busOut = '{
      cyc: busCyc,
      stb: busStb,
      we:  busWe,
      adr: busAdr,
      dat: busDat
   };

   assign devResp = '{err: respErr, data: respData};

   ////////////////////
   // Assertions
   ////////////////////

   // Wishbone: no strobe outside a cycle
   stbInCyc: assert property (@(posedge clk) disable iff (rst)
      busOut.stb |-> busOut.cyc)
      else $error("stb without cyc");

   // Only one device is ever acknowledged
   oneAck: assert property (@(posedge clk) disable iff (rst)
      !(devAck1 && devAck2))
      else $error("both device acks high");

   // Master holds the cycle until the slave acks
   holdCycle: assert property (@(posedge clk) disable iff (rst)
      busOut.stb && !busAck |=> $stable(busOut))
      else $error("bus outputs changed while waiting for ack");

endmodule

`default_nettype wire

// File: hdl/ubaDma.sv
/*
 * Bus adapter DMA path top level
 * Pager feeding the NPR sequencer, device ports and Wishbone master
 */

`default_nettype none

module ubaDma (
   input  logic                              clk,
   input  logic                              rst,
   // Device 1
   input  logic                              devReqValid1,
   input  ubaPkg::devReq_t                   devReq1,
   output logic                              devAck1,
   // Device 2
   input  logic                              devReqValid2,
   input  ubaPkg::devReq_t                   devReq2,
   output logic                              devAck2,
   output ubaPkg::devResp_t                  devResp,
   // Page table configuration
   input  logic                              cfgWrite,
   input  logic [ubaPkg::pageNumWidth-1:0]   cfgPage,
   input  ubaPkg::pageEntry_t                cfgEntry,
   // Backplane
   output ubaPkg::wbMaster_t                 busOut,
   input  logic [ubaPkg::wordWidth-1:0]      busDatIn,
   input  logic                              busAck
);

   // Device address out, translated entry back a cycle later
   logic [ubaPkg::devAddrWidth-1:0] xlateAddr;
   ubaPkg::pageEntry_t              xlateEntry;

   ////////////////////
   // Pager
   ////////////////////

   ubaPager pager_i (
      .clk        (clk),
      .rst        (rst),
      .cfgWrite   (cfgWrite),
      .cfgPage    (cfgPage),
      .cfgEntry   (cfgEntry),
      .xlateAddr  (xlateAddr),
      .xlateEntry (xlateEntry)
   );

   ////////////////////
   // Sequencer
   ////////////////////

   ubaNpr npr_i (
      .clk          (clk),
      .rst          (rst),
      .devReqValid1 (devReqValid1),
      .devReq1      (devReq1),
      .devAck1      (devAck1),
      .devReqValid2 (devReqValid2),
      .devReq2      (devReq2),
      .devAck2      (devAck2),
      .devResp      (devResp),
      .xlateAddr    (xlateAddr),
      .xlateEntry   (xlateEntry),
      .busOut       (busOut),
      .busDatIn     (busDatIn),
      .busAck       (busAck)
   );

endmodule

`default_nettype wire

// File: verification/ubaMemModel.sv
/*
 * Wishbone classic memory responder
 * Sparse 36-bit word store with random wait states and a bus cycle log
 */

`default_nettype none

module ubaMemModel (
   input  logic                          clk,
   input  logic                          rst,
   input  ubaPkg::wbMaster_t             bus,
   // Wait states for the next cycle, drawn by the testbench
   input  logic [1:0]                    waitDraw,
   output logic [ubaPkg::wordWidth-1:0]  datOut,
   output logic                          ack,
   output int                            cycleCount,
   output int                            writeCount
);
   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      logic                            we;
      logic [ubaPkg::busAddrWidth-1:0] adr;
      logic [ubaPkg::wordWidth-1:0]    dat;
   } logEntry_t;

   // Words not yet written read as zero
   logic [ubaPkg::wordWidth-1:0] mem [logic [ubaPkg::busAddrWidth-1:0]];
   logEntry_t                    busLog [$];
   logic                         busy = 1'b0;
   logic [1:0]                   waitLeft = 2'd0;
   logic                         respond;
   logic [ubaPkg::wordWidth-1:0] readWord;

   initial
   begin
      ack = 1'b0;
      datOut = '0;
   end

   // Ack now on a zero draw, or once the wait count runs out
   assign respond = bus.cyc && bus.stb && !ack &&
                    (busy ? (waitLeft == 2'd0) : (waitDraw == 2'd0));

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ack <= 1'b0;
         busy <= 1'b0;
         waitLeft <= 2'd0;
         datOut <= '0;
         cycleCount <= 0;
         writeCount <= 0;
      end
      else
      begin
         ack <= respond;
         if (respond)
         begin
            busy <= 1'b0;
            cycleCount <= cycleCount + 1;
            readWord = mem.exists(bus.adr) ? mem[bus.adr] : '0;
            if (bus.we)
            begin
               mem[bus.adr] = bus.dat;
               writeCount <= writeCount + 1;
            end
            datOut <= readWord;
            // Writes log the data written, reads the word returned
            busLog.push_back('{we: bus.we, adr: bus.adr, dat: bus.we ? bus.dat : readWord});
         end
         else if (bus.cyc && bus.stb && !ack)
         begin
            if (busy)
               waitLeft <= waitLeft - 2'd1;
            else
            begin
               busy <= 1'b1;
               waitLeft <= waitDraw - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verification/ubaDmaTb.sv
/*
 * DMA path testbench
 * Random device traffic checked against a page-table and shadow memory model
 */

`default_nettype none

module ubaDmaTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int numPlain = 20;
   localparam int numRpw   = 20;
   localparam int numReads = 40;
   localparam int numArb   = 20;
   localparam int numMixed = 400;
   // Each plain write brings two reads and each RPW write one read
   localparam int numTxn = 2 + 3 * numPlain + 2 * numRpw + numReads + 2 * numArb + numMixed;
   localparam int cycleLimit = 200 * numTxn + 2000;

   logic                            clk;
   logic                            rst;
   logic                            devReqValid1;
   logic                            devReqValid2;
   ubaPkg::devReq_t                 devReq1;
   ubaPkg::devReq_t                 devReq2;
   logic                            devAck1;
   logic                            devAck2;
   ubaPkg::devResp_t                devResp;
   logic                            cfgWrite;
   logic [ubaPkg::pageNumWidth-1:0] cfgPage;
   ubaPkg::pageEntry_t              cfgEntry;
   ubaPkg::wbMaster_t               busOut;
   logic [ubaPkg::wordWidth-1:0]    busDatIn;
   logic                            busAck;
   logic [1:0]                      waitDraw = 2'd0;
   int                              memCycles;
   int                              memWrites;
   // Reference model
   ubaPkg::pageEntry_t              pageMirror [ubaPkg::pageCount];
   logic [ubaPkg::wordWidth-1:0]    shadow [logic [ubaPkg::busAddrWidth-1:0]];
   logic [31:0]                     rngState = 32'd51585;
   logic [31:0]                     waitRng = ~32'd51585;
   int                              cycles = 0;
   int                              ackCount1 = 0;
   int                              ackCount2 = 0;
   int                              expAck1 = 0;
   int                              expAck2 = 0;
   int                              expWrites = 0;

   ubaDma ubaDma_i (
      .clk          (clk),
      .rst          (rst),
      .devReqValid1 (devReqValid1),
      .devReq1      (devReq1),
      .devAck1      (devAck1),
      .devReqValid2 (devReqValid2),
      .devReq2      (devReq2),
      .devAck2      (devAck2),
      .devResp      (devResp),
      .cfgWrite     (cfgWrite),
      .cfgPage      (cfgPage),
      .cfgEntry     (cfgEntry),
      .busOut       (busOut),
      .busDatIn     (busDatIn),
      .busAck       (busAck)
   );

   ubaMemModel memModel_i (
      .clk        (clk),
      .rst        (rst),
      .bus        (busOut),
      .waitDraw   (waitDraw),
      .datOut     (busDatIn),
      .ack        (busAck),
      .cycleCount (memCycles),
      .writeCount (memWrites)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////
   // Random numbers
   ////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] nextRandom();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   // Separate stream for memory wait states
   always @(posedge clk)
   begin
      #1;
      waitRng = xorshift32(waitRng);
      waitDraw = waitRng[1:0];
   end

   // Ack counters and watchdog
   always @(posedge clk)
   begin
      cycles++;
      if (devAck1)
         ackCount1++;
      if (devAck2)
         ackCount2++;
      if (cycles >= cycleLimit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycleLimit);
         stopOnError();
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   task automatic stopOnError();
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compareResp(input string name, input ubaPkg::devResp_t expected,
                              input ubaPkg::devResp_t actual);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t %s expected err=%0b data=%05h actual err=%0b data=%05h",
                  $time, name, expected.err, expected.data, actual.err, actual.data);
         stopOnError();
      end
   endtask

   task automatic compareWord(input string name, input logic [ubaPkg::wordWidth-1:0] expected,
                              input logic [ubaPkg::wordWidth-1:0] actual);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t %s expected %09h actual %09h", $time, name, expected, actual);
         stopOnError();
      end
   endtask

   task automatic compareCount(input string name, input int expected, input int actual);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
         stopOnError();
      end
   endtask

   ////////////////////
   // Stimulus helpers
   ////////////////////

   // Drive point is 1 ns after the rising edge
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic checkBusIdle();
      compareCount("busOut.cyc", 0, int'(busOut.cyc));
      compareCount("busOut.stb", 0, int'(busOut.stb));
      compareCount("busOut.we", 0, int'(busOut.we));
      compareCount("devAck1", 0, int'(devAck1));
      compareCount("devAck2", 0, int'(devAck2));
   endtask

   // Page 0 is always a valid plain page and page 1 a valid RPW page
   task automatic configurePages();
      logic [31:0] r;
      for (int p = 0; p < ubaPkg::pageCount; p++)
      begin
         r = nextRandom();
         cfgEntry.valid = (p < 2) ? 1'b1 : (r[2:0] != 3'd0);
         cfgEntry.rpw = (p == 1) ? 1'b1 : ((p == 0) ? 1'b0 : r[3]);
         cfgEntry.fill = r[4];
         // Only eight physical pages so device pages alias
         cfgEntry.physPage = {7'd0, r[7:5]};
         cfgPage = p[5:0];
         cfgWrite = 1'b1;
         pageMirror[p] = cfgEntry;
         nextCycle();
      end
      cfgWrite = 1'b0;
      nextCycle();
   endtask

   function automatic logic [5:0] pickPage(input logic wantRpw);
      logic [31:0] r;
      do
         r = nextRandom();
      while (!(pageMirror[r[5:0]].valid && pageMirror[r[5:0]].rpw == wantRpw));
      return r[5:0];
   endfunction

   // Sixteen words per page keep the address space small
   function automatic ubaPkg::devReq_t makeReq(input ubaPkg::devOp_t op, input logic [5:0] page);
      logic [31:0] r;
      ubaPkg::devReq_t q;
      r = nextRandom();
      q.op = op;
      q.addr = {page, 6'd0, r[3:0], r[4], r[5]};
      q.data = r[31:14];
      return q;
   endfunction

   ////////////////////
   // One device transfer with its reference check
   ////////////////////

   task automatic issue(input int dev, input ubaPkg::devReq_t req, input logic checkLog,
                        output time ackTime);
      ubaPkg::pageEntry_t              entry;
      logic [ubaPkg::busAddrWidth-1:0] wordAdr;
      logic [ubaPkg::wordWidth-1:0]    newWord;
      ubaPkg::devResp_t                expResp;
      ubaPkg::devResp_t                gotResp;
      int                              logStart;
      int                              expCycles;
      int                              last;
      logStart = memCycles;
      if (dev == 1)
      begin
         devReq1 = req;
         devReqValid1 = 1'b1;
         expAck1++;
      end
      else
      begin
         devReq2 = req;
         devReqValid2 = 1'b1;
         expAck2++;
      end
      do
         nextCycle();
      while (!((dev == 1) ? devAck1 : devAck2));
      ackTime = $time;
      gotResp = devResp;
      if (dev == 1)
         devReqValid1 = 1'b0;
      else
         devReqValid2 = 1'b0;
      // Expected result from the page and halfword rules
      entry = pageMirror[req.addr[17:12]];
      wordAdr = {entry.physPage, req.addr[11:2]};
      newWord = shadow.exists(wordAdr) ? shadow[wordAdr] : '0;
      expResp = '0;
      expCycles = 0;
      if (!entry.valid)
         expResp.err = 1'b1;
      else if (req.op == ubaPkg::devRead)
      begin
         expResp.data = req.addr[1] ? newWord[17:0] : newWord[35:18];
         expCycles = 1;
      end
      else
      begin
         // Plain write clears the other half and RPW keeps it
         if (!entry.rpw)
            newWord = '0;
         if (req.addr[1])
            newWord[17:0] = req.data;
         else
            newWord[35:18] = req.data;
         shadow[wordAdr] = newWord;
         expCycles = entry.rpw ? 2 : 1;
         expWrites++;
      end
      compareResp($sformatf("devResp (device %0d)", dev), expResp, gotResp);
      if (checkLog)
      begin
         compareCount("bus cycle count", logStart + expCycles, memCycles);
         last = memCycles - 1;
         if (expCycles > 0)
         begin
            compareWord("busLog.adr", {16'd0, wordAdr}, {16'd0, memModel_i.busLog[last].adr});
            compareCount("busLog.we", (req.op == ubaPkg::devWrite) ? 1 : 0,
                         int'(memModel_i.busLog[last].we));
            if (req.op == ubaPkg::devWrite)
               compareWord("busLog.dat", newWord, memModel_i.busLog[last].dat);
         end
         // RPW write follows a read of the same word
         if (expCycles == 2)
         begin
            compareCount("busLog.we (RPW read)", 0, int'(memModel_i.busLog[last - 1].we));
            compareWord("busLog.adr (RPW read)", {16'd0, wordAdr},
                        {16'd0, memModel_i.busLog[last - 1].adr});
         end
      end
      nextCycle();
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      logic [31:0]     r;
      ubaPkg::devReq_t req;
      ubaPkg::devReq_t rd;
      time             t1;
      time             t2;
      rst = 1'b1;
      devReqValid1 = 1'b0;
      devReqValid2 = 1'b0;
      devReq1 = '0;
      devReq2 = '0;
      cfgWrite = 1'b0;
      cfgPage = '0;
      cfgEntry = '0;
      foreach (pageMirror[p])
         pageMirror[p] = '0;
      repeat (4)
      begin
         nextCycle();
         checkBusIdle();
      end
      rst = 1'b0;
      nextCycle();
      checkBusIdle();
      // Both requests hit the empty page table and end in err
      r = nextRandom();
      issue(1, makeReq(ubaPkg::devRead, r[5:0]), 1'b1, t1);
      issue(2, makeReq(ubaPkg::devWrite, r[11:6]), 1'b1, t1);
      compareCount("bus cycles before configuration", 0, memCycles);
      configurePages();
      for (int i = 0; i < numPlain; i++)
      begin
         req = makeReq(ubaPkg::devWrite, pickPage(1'b0));
         issue(1, req, 1'b1, t1);
         rd = req;
         rd.op = ubaPkg::devRead;
         issue(2, rd, 1'b1, t1);
         rd.addr[1] = ~rd.addr[1];
         issue(1, rd, 1'b1, t1);
      end
      for (int i = 0; i < numRpw; i++)
      begin
         req = makeReq(ubaPkg::devWrite, pickPage(1'b1));
         issue(2, req, 1'b1, t1);
         rd = req;
         rd.op = ubaPkg::devRead;
         rd.addr[1] = ~rd.addr[1];
         issue(1, rd, 1'b1, t1);
      end
      for (int i = 0; i < numReads; i++)
      begin
         r = nextRandom();
         issue(r[0] ? 2 : 1, makeReq(ubaPkg::devRead, pickPage(r[1])), 1'b1, t1);
      end
      // Both devices at once against random wait states
      for (int i = 0; i < numArb; i++)
      begin
         r = nextRandom();
         req = makeReq(r[0] ? ubaPkg::devWrite : ubaPkg::devRead, pickPage(r[1]));
         rd = makeReq(r[2] ? ubaPkg::devWrite : ubaPkg::devRead, pickPage(r[3]));
         fork
            issue(1, req, 1'b0, t1);
            issue(2, rd, 1'b0, t2);
         join
         if (t2 <= t1)
         begin
            $display("Arbitration error: device 2 was acknowledged before device 1 at %0t", t2);
            stopOnError();
         end
         compareCount("devAck1 count", expAck1, ackCount1);
         compareCount("devAck2 count", expAck2, ackCount2);
      end
      // Mixed traffic over all pages including invalid ones
      for (int i = 0; i < numMixed; i++)
      begin
         r = nextRandom();
         issue(r[7] ? 2 : 1, makeReq(r[0] ? ubaPkg::devWrite : ubaPkg::devRead, r[6:1]),
               1'b1, t1);
      end
      compareCount("devAck1 count", expAck1, ackCount1);
      compareCount("devAck2 count", expAck2, ackCount2);
      compareCount("memory write cycles", expWrites, memWrites);
      foreach (shadow[a])
      begin
         if (!memModel_i.mem.exists(a))
         begin
            $display("Memory model holds no word at address %05h", a);
            stopOnError();
         end
         compareWord($sformatf("memory word %05h", a), shadow[a], memModel_i.mem[a]);
      end
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
hdl/ubaPkg.sv
hdl/ubaPager.sv
hdl/ubaNpr.sv
hdl/ubaDma.sv
verification/ubaMemModel.sv
verification/ubaDmaTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the DMA path testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module ubaDmaTb -o ubaDmaSim -f verilog.f

./obj_dir/ubaDmaSim | tee sim.log

if grep -qF "** FAIL **" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -qF "** PASS **" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"
